// ==== src/radio_core_pkg.sv ====
// shared slot counts, settings address map and sample types; imported by every radio core module
package radio_core_pkg;

   // ----------------------------------------
   // slot and channel counts
   localparam int NUM_DBOARDS             = 2;
   localparam int NUM_CHANNELS_PER_DBOARD = 2;     // rx channels per slot
   localparam int NUM_CHANNELS            = NUM_DBOARDS * NUM_CHANNELS_PER_DBOARD;

   // bus and pin widths
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;
   localparam int RB_DATA_W  = 64;                 // {high word, low word}
   localparam int GPIO_W     = 32;
   localparam int LED_W      = 3;                  // {rx, txrx_tx, txrx_rx}
   localparam int IQ_W       = 16;                 // one sample component

   typedef logic [SET_ADDR_W-1:0] set_addr_t;
   typedef logic [SET_DATA_W-1:0] set_data_t;
   typedef logic [RB_DATA_W-1:0]  rb_data_t;
   typedef logic [GPIO_W-1:0]     gpio_t;

   // i in the upper half, q in the lower
   typedef struct packed {
      logic [IQ_W-1:0] i;
      logic [IQ_W-1:0] q;
   } sample_t;

   // ----------------------------------------
   // settings address map, same for every slot
   localparam set_addr_t SR_DB_BASE        = 8'd160;
   localparam set_addr_t RB_DB_BASE        = 8'd16;
   localparam set_addr_t SR_TX_FE_BASE     = 8'd208;  // db base + 48
   localparam set_addr_t SR_RX_FE_BASE     = 8'd224;  // db base + 64
   localparam set_addr_t SR_FE_CHAN_OFFSET = 8'd16;

   // db_control offsets
   localparam set_addr_t SR_GPIO_IDLE = 8'd0;
   localparam set_addr_t SR_GPIO_RX   = 8'd1;
   localparam set_addr_t SR_GPIO_TX   = 8'd2;
   localparam set_addr_t SR_GPIO_FDX  = 8'd3;
   localparam set_addr_t SR_GPIO_DDR  = 8'd4;
   localparam set_addr_t SR_MISC_OUT  = 8'd5;

   localparam set_addr_t RB_GPIO_IN   = 8'd0;     // {misc in, gpio in}
   localparam set_addr_t RB_GPIO_OUT  = 8'd1;     // {gpio ddr, gpio out}

   // front-end offsets
   localparam set_addr_t SR_FE_OFFSET = 8'd0;
   localparam set_addr_t SR_FE_CTRL   = 8'd1;

endpackage

// ==== src/fe_iq_corr.sv ====
// one channel of I/Q correction: dc offset subtract, optional swap and Q negate, one register
`timescale 1ns/10ps

module fe_iq_corr #(
   parameter radio_core_pkg::set_addr_t SR_BASE = radio_core_pkg::SR_RX_FE_BASE
) (
   input  logic                        radio_clk,
   input  logic                        i_rst_n,
   // settings bus, shared by the whole slot
   input  logic                        i_set_stb,
   input  radio_core_pkg::set_addr_t   i_set_addr,
   input  radio_core_pkg::set_data_t   i_set_data,
   // sample in and out
   input  logic                        i_stb,
   input  radio_core_pkg::sample_t     i_sample,
   output logic                        o_stb,
   output radio_core_pkg::sample_t     o_sample
);

   import radio_core_pkg::*;

   set_data_t       offset;   // {i offset, q offset}
   logic [1:0]      ctrl;     // bit 0 swap, bit 1 negate q

   logic [IQ_W-1:0] i_sub;
   logic [IQ_W-1:0] q_sub;
   sample_t         corr;

   // ----------------------------------------
   // settings decode
   always_ff @(posedge radio_clk)
   begin
      if (!i_rst_n)
      begin
         offset <= '0;
         ctrl   <= '0;
      end
      else if (i_set_stb)
      begin
         case (i_set_addr)
            SR_BASE + SR_FE_OFFSET : offset <= i_set_data;
            SR_BASE + SR_FE_CTRL   : ctrl   <= i_set_data[1:0];
            default                : ;
         endcase
      end
   end

   // ----------------------------------------
   // correction, all mod 2^16
   assign i_sub = i_sample.i - offset[2*IQ_W-1:IQ_W];
   assign q_sub = i_sample.q - offset[IQ_W-1:0];

   always_comb
   begin
      if (ctrl[0])
      begin
         corr.i = q_sub;   // swap first
         corr.q = i_sub;
      end
      else
      begin
         corr.i = i_sub;
         corr.q = q_sub;
      end
      if (ctrl[1])
         corr.q = -corr.q;   // negate after swap
   end

   // output stage, strobe follows input by one cycle
   always_ff @(posedge radio_clk)
   begin
      if (!i_rst_n)
      begin
         o_stb    <= 1'b0;
         o_sample <= '0;
      end
      else
      begin
         o_stb <= i_stb;
         if (i_stb)
            o_sample <= corr;   // hold last value between strobes
      end
   end

endmodule

// ==== src/db_control.sv ====
// daughterboard control for one slot: settings registers, ATR GPIO select, LEDs and readback
`timescale 1ns/10ps

module db_control (
   input  logic                                radio_clk,
   input  logic                                i_rst_n,
   // settings bus
   input  logic                                i_set_stb,
   input  radio_core_pkg::set_addr_t           i_set_addr,
   input  radio_core_pkg::set_data_t           i_set_data,
   // readback bus
   input  logic                                i_rb_stb,
   input  radio_core_pkg::set_addr_t           i_rb_addr,
   output radio_core_pkg::rb_data_t            o_rb_data,
   // slot run state, already or'ed over channels
   input  logic                                i_run_rx,
   input  logic                                i_run_tx,
   // daughterboard pins
   input  radio_core_pkg::gpio_t               i_db_gpio_in,
   input  radio_core_pkg::set_data_t           i_misc_in,
   output radio_core_pkg::gpio_t               o_db_gpio_out,
   output radio_core_pkg::gpio_t               o_db_gpio_ddr,
   output logic [radio_core_pkg::LED_W-1:0]    o_radio_led,
   output radio_core_pkg::set_data_t           o_misc_out
);

   import radio_core_pkg::*;

   gpio_t gpio_idle;   // atr words, one per state
   gpio_t gpio_rx;
   gpio_t gpio_tx;
   gpio_t gpio_fdx;

   logic [1:0] atr_state;

   assign atr_state = {i_run_tx, i_run_rx};

   // ----------------------------------------
   // settings registers
   always_ff @(posedge radio_clk)
   begin
      if (!i_rst_n)
      begin
         gpio_idle     <= '0;
         gpio_rx       <= '0;
         gpio_tx       <= '0;
         gpio_fdx      <= '0;
         o_db_gpio_ddr <= '0;
         o_misc_out    <= '0;
      end
      else if (i_set_stb)
      begin
         case (i_set_addr)                          // other addresses belong to the front ends
            SR_DB_BASE + SR_GPIO_IDLE : gpio_idle     <= i_set_data;
            SR_DB_BASE + SR_GPIO_RX   : gpio_rx       <= i_set_data;
            SR_DB_BASE + SR_GPIO_TX   : gpio_tx       <= i_set_data;
            SR_DB_BASE + SR_GPIO_FDX  : gpio_fdx      <= i_set_data;
            SR_DB_BASE + SR_GPIO_DDR  : o_db_gpio_ddr <= i_set_data;  // straight to pins
            SR_DB_BASE + SR_MISC_OUT  : o_misc_out    <= i_set_data;
            default                   : ;
         endcase
      end
   end

   // ----------------------------------------
   // atr select and leds
   always_ff @(posedge radio_clk)
   begin
      if (!i_rst_n)
      begin
         o_db_gpio_out <= '0;
         o_radio_led   <= '0;
      end
      else
      begin
         case (atr_state)
            2'b00   : o_db_gpio_out <= gpio_idle;
            2'b01   : o_db_gpio_out <= gpio_rx;
            2'b10   : o_db_gpio_out <= gpio_tx;
            default : o_db_gpio_out <= gpio_fdx;   // both running
         endcase
         // rx led, tx/rx port in tx, tx/rx port in rx
         o_radio_led <= {i_run_rx, i_run_tx, i_run_rx & ~i_run_tx};
      end
   end

   // ----------------------------------------
   // readback, held until next strobe
   always_ff @(posedge radio_clk)
   begin
      if (!i_rst_n)
         o_rb_data <= '0;
      else if (i_rb_stb)
      begin
         case (i_rb_addr)
            RB_DB_BASE + RB_GPIO_IN  : o_rb_data <= {i_misc_in, i_db_gpio_in};
            RB_DB_BASE + RB_GPIO_OUT : o_rb_data <= {o_db_gpio_ddr, o_db_gpio_out};
            default                  : o_rb_data <= '0;   // unmapped reads as zero
         endcase
      end
   end

endmodule

// ==== src/radio_core.sv ====
// radio-side core for all daughterboard slots: db control plus rx/tx front ends per slot
`timescale 1ns/10ps

module radio_core (
   input  logic                                                       radio_clk,
   input  logic                                                       i_rst_n,
   // settings and readback, one bus per slot
   input  logic [radio_core_pkg::NUM_DBOARDS-1:0]                     i_set_stb,
   input  radio_core_pkg::set_addr_t [radio_core_pkg::NUM_DBOARDS-1:0] i_set_addr,
   input  radio_core_pkg::set_data_t [radio_core_pkg::NUM_DBOARDS-1:0] i_set_data,
   input  logic [radio_core_pkg::NUM_DBOARDS-1:0]                     i_rb_stb,
   input  radio_core_pkg::set_addr_t [radio_core_pkg::NUM_DBOARDS-1:0] i_rb_addr,
   output radio_core_pkg::rb_data_t  [radio_core_pkg::NUM_DBOARDS-1:0] o_rb_data,
   // adc / dac samples per slot
   input  radio_core_pkg::sample_t   [radio_core_pkg::NUM_DBOARDS-1:0] i_rx,
   input  logic [radio_core_pkg::NUM_DBOARDS-1:0]                     i_rx_stb,
   input  radio_core_pkg::sample_t   [radio_core_pkg::NUM_DBOARDS-1:0] i_tx_data,
   output radio_core_pkg::sample_t   [radio_core_pkg::NUM_DBOARDS-1:0] o_tx,
   // per channel
   input  logic [radio_core_pkg::NUM_CHANNELS-1:0]                    i_rx_running,
   input  logic [radio_core_pkg::NUM_CHANNELS-1:0]                    i_tx_running,
   output radio_core_pkg::sample_t   [radio_core_pkg::NUM_CHANNELS-1:0] o_rx_data,
   output logic [radio_core_pkg::NUM_CHANNELS-1:0]                    o_rx_stb,
   // daughterboard pins per slot
   input  radio_core_pkg::gpio_t     [radio_core_pkg::NUM_DBOARDS-1:0] i_db_gpio_in,
   output radio_core_pkg::gpio_t     [radio_core_pkg::NUM_DBOARDS-1:0] o_db_gpio_out,
   output radio_core_pkg::gpio_t     [radio_core_pkg::NUM_DBOARDS-1:0] o_db_gpio_ddr,
   output logic [radio_core_pkg::NUM_DBOARDS-1:0][radio_core_pkg::LED_W-1:0] o_radio_led,
   input  radio_core_pkg::set_data_t [radio_core_pkg::NUM_DBOARDS-1:0] i_misc_in,
   output radio_core_pkg::set_data_t [radio_core_pkg::NUM_DBOARDS-1:0] o_misc_out
);

   import radio_core_pkg::*;

   set_data_t [NUM_DBOARDS-1:0]  misc_in_r;    // registered misc in, seen by readback
   set_data_t [NUM_DBOARDS-1:0]  misc_out_db;  // misc word from db_control
   logic      [NUM_DBOARDS-1:0]  run_rx;       // slot atr state
   logic      [NUM_DBOARDS-1:0]  run_tx;
   sample_t   [NUM_CHANNELS-1:0] rx_fan;       // slot sample copied per channel
   logic      [NUM_CHANNELS-1:0] rx_stb_fan;

   // ----------------------------------------
   // per-slot logic
   for (genvar s = 0; s < NUM_DBOARDS; s++)
   begin : g_slot

      // one db_control per slot, so channels share the atr state
      assign run_rx[s] = |i_rx_running[s*NUM_CHANNELS_PER_DBOARD +: NUM_CHANNELS_PER_DBOARD];
      assign run_tx[s] = |i_tx_running[s*NUM_CHANNELS_PER_DBOARD +: NUM_CHANNELS_PER_DBOARD];

      // misc words, one register each way
      always_ff @(posedge radio_clk)
      begin
         if (!i_rst_n)
         begin
            misc_in_r[s]  <= '0;
            o_misc_out[s] <= '0;
         end
         else
         begin
            misc_in_r[s]  <= i_misc_in[s];
            o_misc_out[s] <= misc_out_db[s];   // second cycle of misc out latency
         end
      end

      db_control u_db_control (
         .radio_clk     (radio_clk),
         .i_rst_n       (i_rst_n),
         .i_set_stb     (i_set_stb[s]),
         .i_set_addr    (i_set_addr[s]),
         .i_set_data    (i_set_data[s]),
         .i_rb_stb      (i_rb_stb[s]),
         .i_rb_addr     (i_rb_addr[s]),
         .o_rb_data     (o_rb_data[s]),
         .i_run_rx      (run_rx[s]),
         .i_run_tx      (run_tx[s]),
         .i_db_gpio_in  (i_db_gpio_in[s]),
         .i_misc_in     (misc_in_r[s]),
         .o_db_gpio_out (o_db_gpio_out[s]),
         .o_db_gpio_ddr (o_db_gpio_ddr[s]),
         .o_radio_led   (o_radio_led[s]),
         .o_misc_out    (misc_out_db[s])
      );

      // tx channel 0 only, channel 1 never reaches a pin
      fe_iq_corr #(
         .SR_BASE (SR_TX_FE_BASE)
      ) u_tx_fe (
         .radio_clk  (radio_clk),
         .i_rst_n    (i_rst_n),
         .i_set_stb  (i_set_stb[s]),
         .i_set_addr (i_set_addr[s]),
         .i_set_data (i_set_data[s]),
         .i_stb      (1'b1),            // dac data always valid
         .i_sample   (i_tx_data[s]),
         .o_stb      (),
         .o_sample   (o_tx[s])
      );

      // ----------------------------------------
      // rx channels of this slot
      for (genvar c = 0; c < NUM_CHANNELS_PER_DBOARD; c++)
      begin : g_chan

         // both channels see the same adc sample
         assign rx_fan[s*NUM_CHANNELS_PER_DBOARD + c]     = i_rx[s];
         assign rx_stb_fan[s*NUM_CHANNELS_PER_DBOARD + c] = i_rx_stb[s];

         fe_iq_corr #(
            .SR_BASE (set_addr_t'(SR_RX_FE_BASE + c*SR_FE_CHAN_OFFSET))
         ) u_rx_fe (
            .radio_clk  (radio_clk),
            .i_rst_n    (i_rst_n),
            .i_set_stb  (i_set_stb[s]),
            .i_set_addr (i_set_addr[s]),
            .i_set_data (i_set_data[s]),
            .i_stb      (rx_stb_fan[s*NUM_CHANNELS_PER_DBOARD + c]),
            .i_sample   (rx_fan[s*NUM_CHANNELS_PER_DBOARD + c]),
            .o_stb      (o_rx_stb[s*NUM_CHANNELS_PER_DBOARD + c]),
            .o_sample   (o_rx_data[s*NUM_CHANNELS_PER_DBOARD + c])
         );
      end
   end

endmodule

// ==== test/radio_core_checker.sv ====
// testbench checker for radio_core: mirrors settings writes, predicts every output, reports per test
`timescale 1ns/10ps

module radio_core_checker (
   input  logic                                                        radio_clk,
   input  logic                                                        i_rst_n,
   input  int                                                          i_test_num,
   input  logic                                                        i_test_done,
   input  logic [radio_core_pkg::NUM_DBOARDS-1:0]                      i_set_stb,
   input  radio_core_pkg::set_addr_t [radio_core_pkg::NUM_DBOARDS-1:0] i_set_addr,
   input  radio_core_pkg::set_data_t [radio_core_pkg::NUM_DBOARDS-1:0] i_set_data,
   input  logic [radio_core_pkg::NUM_DBOARDS-1:0]                      i_rb_stb,
   input  radio_core_pkg::set_addr_t [radio_core_pkg::NUM_DBOARDS-1:0] i_rb_addr,
   input  radio_core_pkg::rb_data_t  [radio_core_pkg::NUM_DBOARDS-1:0] i_rb_data,
   input  radio_core_pkg::sample_t   [radio_core_pkg::NUM_DBOARDS-1:0] i_rx,
   input  logic [radio_core_pkg::NUM_DBOARDS-1:0]                      i_rx_stb,
   input  radio_core_pkg::sample_t   [radio_core_pkg::NUM_DBOARDS-1:0] i_tx_data,
   input  radio_core_pkg::sample_t   [radio_core_pkg::NUM_DBOARDS-1:0] i_tx,
   input  logic [radio_core_pkg::NUM_CHANNELS-1:0]                     i_rx_running,
   input  logic [radio_core_pkg::NUM_CHANNELS-1:0]                     i_tx_running,
   input  radio_core_pkg::sample_t   [radio_core_pkg::NUM_CHANNELS-1:0] i_rx_data,
   input  logic [radio_core_pkg::NUM_CHANNELS-1:0]                     i_rx_stb_out,
   input  radio_core_pkg::gpio_t     [radio_core_pkg::NUM_DBOARDS-1:0] i_db_gpio_in,
   input  radio_core_pkg::gpio_t     [radio_core_pkg::NUM_DBOARDS-1:0] i_db_gpio_out,
   input  radio_core_pkg::gpio_t     [radio_core_pkg::NUM_DBOARDS-1:0] i_db_gpio_ddr,
   input  logic [radio_core_pkg::NUM_DBOARDS-1:0][radio_core_pkg::LED_W-1:0] i_radio_led,
   input  radio_core_pkg::set_data_t [radio_core_pkg::NUM_DBOARDS-1:0] i_misc_in,
   input  radio_core_pkg::set_data_t [radio_core_pkg::NUM_DBOARDS-1:0] i_misc_out,
   output int                                                          o_tests_done,
   output int                                                          o_fail_cnt
);

   import radio_core_pkg::*;

   localparam int NUM_TESTS = 5;
   localparam int CPD       = NUM_CHANNELS_PER_DBOARD;

   // mirrored settings
   gpio_t      atr_word  [NUM_DBOARDS][4];   // idle, rx, tx, fdx
   gpio_t      ddr_m     [NUM_DBOARDS];      // also the expected ddr pins
   set_data_t  misc_m    [NUM_DBOARDS];      // db_control stage of misc out
   set_data_t  misc_in_m [NUM_DBOARDS];      // top-level misc in register
   set_data_t  tx_off    [NUM_DBOARDS];
   logic [1:0] tx_ctl    [NUM_DBOARDS];
   set_data_t  rx_off    [NUM_CHANNELS];
   logic [1:0] rx_ctl    [NUM_CHANNELS];

   // predicted outputs for the next edge
   logic [31:0]      exp_rx_data  [NUM_CHANNELS];
   logic             exp_rx_stb   [NUM_CHANNELS];
   logic [31:0]      exp_tx       [NUM_DBOARDS];
   gpio_t            exp_gpio_out [NUM_DBOARDS];
   logic [LED_W-1:0] exp_led      [NUM_DBOARDS];
   set_data_t        exp_misc_out [NUM_DBOARDS];
   rb_data_t         exp_rb       [NUM_DBOARDS];

   logic chk_on       = 1'b0;   // set once reset was seen at an edge
   int   test_err     = 0;
   int   fail_cnt     = 0;
   int   failed_tests = 0;
   int   tests_done   = 0;

   assign o_tests_done = tests_done;
   assign o_fail_cnt   = fail_cnt;

   // ----------------------------------------
   // reference functions
   function automatic logic [31:0] corr_ref(input logic [31:0] s, input set_data_t off,
                                            input logic [1:0] ctl);
      logic [15:0] i;
      logic [15:0] q;
      logic [15:0] t;
      i = s[31:16] - off[31:16];   // wraps mod 2^16
      q = s[15:0] - off[15:0];
      if (ctl[0])
      begin
         t = i;
         i = q;
         q = t;
      end
      if (ctl[1])
         q = -q;
      return {i, q};
   endfunction

   function automatic gpio_t atr_ref(input gpio_t idle, input gpio_t rx, input gpio_t tx,
                                     input gpio_t fdx, input logic rx_act, input logic tx_act);
      if (rx_act && tx_act)
         return fdx;
      else if (tx_act)
         return tx;
      else if (rx_act)
         return rx;
      return idle;
   endfunction

   function automatic logic [LED_W-1:0] led_ref(input logic rx_act, input logic tx_act);
      return {rx_act, tx_act, rx_act && !tx_act};   // {rx, txrx_tx, txrx_rx}
   endfunction

   function automatic rb_data_t rb_ref(input set_addr_t addr, input set_data_t misc_in,
                                       input gpio_t gpio_in, input gpio_t ddr, input gpio_t gout);
      if (addr == RB_DB_BASE + RB_GPIO_IN)
         return {misc_in, gpio_in};
      else if (addr == RB_DB_BASE + RB_GPIO_OUT)
         return {ddr, gout};
      return '0;   // unmapped
   endfunction

   function automatic string test_name(input int n);
      case (n)
         1       : return "reset";
         2       : return "rx_corr";
         3       : return "tx_corr";
         4       : return "atr_gpio";
         5       : return "readback_misc";
         default : return "none";
      endcase
   endfunction

   task automatic check(input string what, input int idx, input logic [63:0] exp,
                        input logic [63:0] act);
      if (act !== exp)
      begin
         $display("ERR %s %s[%0d]: expected %h actual %h", test_name(i_test_num), what, idx,
                  exp, act);
         test_err++;
      end
   endtask

   task automatic clear_model();
      for (int s = 0; s < NUM_DBOARDS; s++)
      begin
         for (int w = 0; w < 4; w++)
            atr_word[s][w] = '0;
         ddr_m[s]        = '0;
         misc_m[s]       = '0;
         misc_in_m[s]    = '0;
         tx_off[s]       = '0;
         tx_ctl[s]       = '0;
         exp_tx[s]       = '0;
         exp_gpio_out[s] = '0;
         exp_led[s]      = '0;
         exp_misc_out[s] = '0;
         exp_rb[s]       = '0;
      end
      for (int c = 0; c < NUM_CHANNELS; c++)
      begin
         rx_off[c]      = '0;
         rx_ctl[c]      = '0;
         exp_rx_data[c] = '0;
         exp_rx_stb[c]  = 1'b0;
      end
   endtask

   // ----------------------------------------
   // compare, then step the model one edge
   always @(posedge radio_clk)
   begin
      set_addr_t a;
      set_data_t d;
      logic      rx_act;
      logic      tx_act;
      if (chk_on)
      begin
         for (int s = 0; s < NUM_DBOARDS; s++)
         begin
            check("o_tx", s, 64'(exp_tx[s]), 64'(i_tx[s]));
            check("o_db_gpio_out", s, 64'(exp_gpio_out[s]), 64'(i_db_gpio_out[s]));
            check("o_db_gpio_ddr", s, 64'(ddr_m[s]), 64'(i_db_gpio_ddr[s]));
            check("o_radio_led", s, 64'(exp_led[s]), 64'(i_radio_led[s]));
            check("o_misc_out", s, 64'(exp_misc_out[s]), 64'(i_misc_out[s]));
            check("o_rb_data", s, exp_rb[s], i_rb_data[s]);
         end
         for (int c = 0; c < NUM_CHANNELS; c++)
         begin
            check("o_rx_stb", c, 64'(exp_rx_stb[c]), 64'(i_rx_stb_out[c]));
            if (exp_rx_stb[c])
               check("o_rx_data", c, 64'(exp_rx_data[c]), 64'(i_rx_data[c]));
         end
      end

      if (!i_rst_n)
      begin
         chk_on = 1'b1;
         clear_model();
      end
      else
      begin
         for (int s = 0; s < NUM_DBOARDS; s++)
         begin
            rx_act = |i_rx_running[s*CPD +: CPD];   // slot atr state
            tx_act = |i_tx_running[s*CPD +: CPD];
            if (i_rb_stb[s])   // sees pins as they are before this edge
               exp_rb[s] = rb_ref(i_rb_addr[s], misc_in_m[s], i_db_gpio_in[s], ddr_m[s],
                                  exp_gpio_out[s]);
            exp_gpio_out[s] = atr_ref(atr_word[s][0], atr_word[s][1], atr_word[s][2],
                                      atr_word[s][3], rx_act, tx_act);
            exp_led[s]      = led_ref(rx_act, tx_act);
            exp_misc_out[s] = misc_m[s];
            misc_in_m[s]    = i_misc_in[s];
            exp_tx[s]       = corr_ref(i_tx_data[s], tx_off[s], tx_ctl[s]);
            for (int cc = 0; cc < CPD; cc++)
            begin
               exp_rx_stb[s*CPD + cc] = i_rx_stb[s];   // same adc sample on both channels
               if (i_rx_stb[s])
                  exp_rx_data[s*CPD + cc] = corr_ref(i_rx[s], rx_off[s*CPD + cc],
                                                     rx_ctl[s*CPD + cc]);
            end
            // settings write takes effect from the next edge
            if (i_set_stb[s])
            begin
               a = i_set_addr[s];
               d = i_set_data[s];
               case (a)
                  SR_DB_BASE + SR_GPIO_IDLE    : atr_word[s][0] = d;
                  SR_DB_BASE + SR_GPIO_RX      : atr_word[s][1] = d;
                  SR_DB_BASE + SR_GPIO_TX      : atr_word[s][2] = d;
                  SR_DB_BASE + SR_GPIO_FDX     : atr_word[s][3] = d;
                  SR_DB_BASE + SR_GPIO_DDR     : ddr_m[s]       = d;
                  SR_DB_BASE + SR_MISC_OUT     : misc_m[s]      = d;
                  SR_TX_FE_BASE + SR_FE_OFFSET : tx_off[s]      = d;
                  SR_TX_FE_BASE + SR_FE_CTRL   : tx_ctl[s]      = d[1:0];
                  SR_RX_FE_BASE + SR_FE_OFFSET : rx_off[s*CPD]  = d;
                  SR_RX_FE_BASE + SR_FE_CTRL   : rx_ctl[s*CPD]  = d[1:0];
                  SR_RX_FE_BASE + SR_FE_CHAN_OFFSET + SR_FE_OFFSET : rx_off[s*CPD + 1] = d;
                  SR_RX_FE_BASE + SR_FE_CHAN_OFFSET + SR_FE_CTRL   : rx_ctl[s*CPD + 1] = d[1:0];
                  default : ;
               endcase
            end
         end
      end

      // per-test report
      if (i_test_done)
      begin
         if (test_err == 0)
            $display("test %0d %s: ok", i_test_num, test_name(i_test_num));
         else
         begin
            $display("test %0d %s: %0d checks failed", i_test_num, test_name(i_test_num),
                     test_err);
            failed_tests++;
         end
         fail_cnt   = fail_cnt + test_err;
         test_err   = 0;
         tests_done = tests_done + 1;
         if (tests_done == NUM_TESTS)
            $display("tests run %0d, tests failed %0d, checks failed %0d", tests_done,
                     failed_tests, fail_cnt);
      end
   end

endmodule

// ==== test/tb_radio_core.sv ====
// testbench top for radio_core: clock, reset, lcg stimulus and test sequencing with the checker
`timescale 1ns/10ps

module tb_radio_core;

   import radio_core_pkg::*;

   localparam int NUM_TESTS = 5;
   localparam int WAIT_MAX  = 20;   // cycles to wait for a checker report

   logic                                       radio_clk;
   logic                                       i_rst_n;
   logic [NUM_DBOARDS-1:0]                     i_set_stb;
   set_addr_t [NUM_DBOARDS-1:0]                i_set_addr;
   set_data_t [NUM_DBOARDS-1:0]                i_set_data;
   logic [NUM_DBOARDS-1:0]                     i_rb_stb;
   set_addr_t [NUM_DBOARDS-1:0]                i_rb_addr;
   rb_data_t  [NUM_DBOARDS-1:0]                o_rb_data;
   sample_t   [NUM_DBOARDS-1:0]                i_rx;
   logic [NUM_DBOARDS-1:0]                     i_rx_stb;
   sample_t   [NUM_DBOARDS-1:0]                i_tx_data;
   sample_t   [NUM_DBOARDS-1:0]                o_tx;
   logic [NUM_CHANNELS-1:0]                    i_rx_running;
   logic [NUM_CHANNELS-1:0]                    i_tx_running;
   sample_t   [NUM_CHANNELS-1:0]               o_rx_data;
   logic [NUM_CHANNELS-1:0]                    o_rx_stb;
   gpio_t     [NUM_DBOARDS-1:0]                i_db_gpio_in;
   gpio_t     [NUM_DBOARDS-1:0]                o_db_gpio_out;
   gpio_t     [NUM_DBOARDS-1:0]                o_db_gpio_ddr;
   logic [NUM_DBOARDS-1:0][LED_W-1:0]          o_radio_led;
   set_data_t [NUM_DBOARDS-1:0]                i_misc_in;
   set_data_t [NUM_DBOARDS-1:0]                o_misc_out;

   logic [31:0] lcg_state;
   logic [31:0] r;
   int          test_num;
   logic        test_done;
   int          tests_done;
   int          fail_cnt;
   logic        timed_out;   // checker report never came

   radio_core i_radio_core (.*);

   radio_core_checker u_checker (
      .*,
      .i_test_num    (test_num),
      .i_test_done   (test_done),
      .i_rb_data     (o_rb_data),
      .i_tx          (o_tx),
      .i_rx_data     (o_rx_data),
      .i_rx_stb_out  (o_rx_stb),
      .i_db_gpio_out (o_db_gpio_out),
      .i_db_gpio_ddr (o_db_gpio_ddr),
      .i_radio_led   (o_radio_led),
      .i_misc_out    (o_misc_out),
      .o_tests_done  (tests_done),
      .o_fail_cnt    (fail_cnt)
   );

   initial radio_clk = 1'b0;
   always #2 radio_clk = ~radio_clk;   // 4 ns period

   // ----------------------------------------
   // stimulus helpers
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic tick();
      @(posedge radio_clk);
      #1;   // inputs change just after the edge
   endtask

   task automatic write_set(input int s, input set_addr_t addr, input set_data_t data);
      i_set_stb[s]  = 1'b1;
      i_set_addr[s] = addr;
      i_set_data[s] = data;
      tick();
      i_set_stb[s] = 1'b0;
   endtask

   // flush the pipeline, pulse done, wait for the checker's report
   task automatic finish_test();
      int cnt;
      cnt = 0;
      tick();
      tick();   // misc out needs two edges
      test_done = 1'b1;
      tick();
      test_done = 1'b0;
      while (tests_done < test_num && cnt < WAIT_MAX)
      begin
         tick();
         cnt++;
      end
      if (tests_done < test_num)
      begin
         $display("timeout: checker never reported test %0d", test_num);
         timed_out = 1'b1;
      end
   endtask

   // ----------------------------------------
   // test sequence, stops early on a timeout
   task automatic run_tests();
      test_num = 1;   // reset
      for (int k = 0; k < 4; k++)
         tick();
      i_rst_n = 1'b1;
      finish_test();
      if (timed_out)
         return;

      test_num = 2;   // rx correction, offsets and ctrl per channel
      for (int s = 0; s < NUM_DBOARDS; s++)
         for (int c = 0; c < NUM_CHANNELS_PER_DBOARD; c++)
         begin
            write_set(s, set_addr_t'(SR_RX_FE_BASE + c*SR_FE_CHAN_OFFSET + SR_FE_OFFSET),
                      next_rand());
            write_set(s, set_addr_t'(SR_RX_FE_BASE + c*SR_FE_CHAN_OFFSET + SR_FE_CTRL),
                      next_rand());
         end
      for (int k = 0; k < 32; k++)
      begin
         for (int s = 0; s < NUM_DBOARDS; s++)
         begin
            r           = next_rand();
            i_rx[s]     = next_rand();
            i_rx_stb[s] = r[0] | r[1];   // mostly back to back
         end
         tick();
      end
      i_rx_stb = '0;
      finish_test();
      if (timed_out)
         return;

      test_num = 3;   // tx correction
      for (int s = 0; s < NUM_DBOARDS; s++)
      begin
         write_set(s, SR_TX_FE_BASE + SR_FE_OFFSET, next_rand());
         write_set(s, SR_TX_FE_BASE + SR_FE_CTRL, next_rand());
      end
      for (int k = 0; k < 32; k++)
      begin
         for (int s = 0; s < NUM_DBOARDS; s++)
            i_tx_data[s] = next_rand();
         tick();
      end
      finish_test();
      if (timed_out)
         return;

      test_num = 4;   // atr words, ddr, then all run flag combinations
      for (int s = 0; s < NUM_DBOARDS; s++)
         for (int w = 0; w <= 4; w++)
            write_set(s, set_addr_t'(SR_DB_BASE + w), next_rand());   // idle .. ddr
      for (int k = 0; k < 256; k++)
      begin
         i_rx_running = k[3:0];
         i_tx_running = k[7:4];
         tick();
      end
      i_rx_running = '0;
      i_tx_running = '0;
      finish_test();
      if (timed_out)
         return;

      test_num = 5;   // misc out, then both readback words and one unmapped
      for (int s = 0; s < NUM_DBOARDS; s++)
         write_set(s, SR_DB_BASE + SR_MISC_OUT, next_rand());
      for (int k = 0; k < 3; k++)
      begin
         for (int s = 0; s < NUM_DBOARDS; s++)
            i_misc_in[s] = next_rand();
         tick();
         for (int s = 0; s < NUM_DBOARDS; s++)
         begin
            i_misc_in[s]    = next_rand();   // registered copy still holds the last one
            i_db_gpio_in[s] = next_rand();
            i_rb_stb[s]     = 1'b1;
            i_rb_addr[s]    = (k == 2) ? 8'd99 : set_addr_t'(RB_DB_BASE + k);
         end
         tick();
         i_rb_stb = '0;
         tick();
      end
      finish_test();
   endtask

   initial
   begin
      lcg_state    = 32'd50;
      i_rst_n      = 1'b0;
      i_set_stb    = '0;
      i_set_addr   = '0;
      i_set_data   = '0;
      i_rb_stb     = '0;
      i_rb_addr    = '0;
      i_rx         = '0;
      i_rx_stb     = '0;
      i_tx_data    = '0;
      i_rx_running = '0;
      i_tx_running = '0;
      i_db_gpio_in = '0;
      i_misc_in    = '0;
      test_done    = 1'b0;
      timed_out    = 1'b0;

      run_tests();

      if (timed_out)
         $display("Simulation finished: FAIL");
      else if (fail_cnt == 0 && tests_done == NUM_TESTS)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== build.f ====
src/radio_core_pkg.sv
src/fe_iq_corr.sv
src/db_control.sv
src/radio_core.sv
test/radio_core_checker.sv
test/tb_radio_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the radio core testbench with verilator and runs it, exit status follows the result
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Mdir obj_dir -f build.f --top-module tb_radio_core \
      -o sim_radio_core; then
   echo "verilator build failed"
   exit 1
fi

if ! sim_out=$(./obj_dir/sim_radio_core 2>&1); then
   echo "$sim_out"
   echo "simulation binary exited with an error"
   exit 1
fi
echo "$sim_out"

if echo "$sim_out" | grep -q "Simulation finished: PASS"; then
   exit 0
fi
exit 1
